// File: logic/ac.sv
// Accumulator and link

`timescale 1ns/1ps
`default_nettype none

`include "pdp8_cfg.svh"

module ac (
    input  logic                       clk,
    input  logic                       rst_n,
    input  pdp8_isa_pkg::major_state_t state,
    input  logic [0:`PDP8_WORD_W-1]    instruction,
    input  logic [0:`PDP8_WORD_W-1]    mdout,
    input  logic [0:`PDP8_WORD_W-1]    sr,
    output logic [0:`PDP8_WORD_W-1]    ac,
    output logic                       link
);
    localparam int W    = `PDP8_WORD_W;
    localparam int HALF = W / 2;

    pdp8_isa_pkg::opcode_t opcode;
    logic [0:W-1]          ac_next;
    logic                  link_next;
    logic [0:W]            lac;
    logic [0:W]            sum;

    assign opcode = pdp8_isa_pkg::opcode_t'(instruction[0:2]);

    always_comb
    begin
        ac_next   = ac;
        link_next = link;
        // Link rides in bit 0 so carries and rotates pass through it.
        lac       = {link, ac};
        sum       = {1'b0, ac} + {1'b0, mdout};
        case (opcode)
            pdp8_isa_pkg::OP_AND: ac_next = ac & mdout;
            pdp8_isa_pkg::OP_TAD:
            begin
                ac_next   = sum[1:W];
                link_next = link ^ sum[0];
            end
            pdp8_isa_pkg::OP_DCA: ac_next = '0;
            pdp8_isa_pkg::OP_OPR:
            begin
                if (!instruction[pdp8_isa_pkg::GRP_BIT])
                begin
                    if (instruction[pdp8_isa_pkg::CLA_BIT]) lac[1:W] = '0;
                    if (instruction[pdp8_isa_pkg::CLL_BIT]) lac[0] = 1'b0;
                    if (instruction[pdp8_isa_pkg::CMA_BIT]) lac[1:W] = ~lac[1:W];
                    if (instruction[pdp8_isa_pkg::CML_BIT]) lac[0] = ~lac[0];
                    if (instruction[pdp8_isa_pkg::IAC_BIT]) lac = lac + 1'b1;
                    case ({instruction[pdp8_isa_pkg::RAR_BIT], instruction[pdp8_isa_pkg::RAL_BIT],
                           instruction[pdp8_isa_pkg::TWO_BIT]})
                        3'b100: lac = {lac[W], lac[0:W-1]};
                        3'b101: lac = {lac[W-1:W], lac[0:W-2]};
                        3'b010: lac = {lac[1:W], lac[0]};
                        3'b011: lac = {lac[2:W], lac[0:1]};
                        3'b001: lac[1:W] = {lac[1+HALF:W], lac[1:HALF]};
                        default: ;
                    endcase
                    ac_next   = lac[1:W];
                    link_next = lac[0];
                end
                else
                begin
                    if (instruction[pdp8_isa_pkg::CLA_BIT]) ac_next = '0;
                    if (instruction[pdp8_isa_pkg::OSR_BIT]) ac_next = ac_next | sr;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ac   <= '0;
            link <= 1'b0;
        end
        else if (state == pdp8_isa_pkg::ST_EXEC)
        begin
            ac   <= ac_next;
            link <= link_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/front_panel.sv
// Front panel switch decoder

`timescale 1ns/1ps
`default_nettype none

module front_panel (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  run,
    input  logic                  load_sw,
    input  logic                  dep_sw,
    input  logic                  exam_sw,
    input  logic                  cont_sw,
    output panel_pkg::panel_cmd_t panel_cmd
);
    // Bit 0 load, 1 deposit, 2 examine, 3 continue.
    logic [3:0] sync1;
    logic [3:0] sync2;
    logic [3:0] prev;
    logic [3:0] rise;

    assign rise = sync2 & ~prev;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync1     <= '0;
            sync2     <= '0;
            prev      <= '0;
            panel_cmd <= panel_pkg::PNL_NONE;
        end
        else
        begin
            sync1 <= {cont_sw, exam_sw, dep_sw, load_sw};
            sync2 <= sync1;
            prev  <= sync2;
            // Machine leaves HALT on the cycle after CONT.
            if (run || panel_cmd == panel_pkg::PNL_CONT)
                panel_cmd <= panel_pkg::PNL_NONE;
            else if (rise[0])
                panel_cmd <= panel_pkg::PNL_LOAD;
            else if (rise[1])
                panel_cmd <= panel_pkg::PNL_DEP;
            else if (rise[2])
                panel_cmd <= panel_pkg::PNL_EXAM;
            else if (rise[3])
                panel_cmd <= panel_pkg::PNL_CONT;
            else
                panel_cmd <= panel_pkg::PNL_NONE;
        end
    end

endmodule

`default_nettype wire

// File: logic/ma.sv
// Memory address and core memory

`timescale 1ns/1ps
`default_nettype none

`include "pdp8_cfg.svh"

module ma (
    input  logic                       clk,
    input  logic                       rst_n,
    input  pdp8_isa_pkg::major_state_t state,
    input  panel_pkg::panel_cmd_t      panel_cmd,
    input  logic [0:`PDP8_WORD_W-1]    sr,
    input  logic [0:`PDP8_WORD_W-1]    ac,
    input  logic                       skip,
    output logic [0:`PDP8_WORD_W-1]    instruction,
    output logic [0:`PDP8_WORD_W-1]    mdout,
    output logic [0:`PDP8_ADDR_W-1]    pc,
    output logic [0:`PDP8_WORD_W-1]    mb
);
    localparam int W     = `PDP8_WORD_W;
    localparam int AW    = `PDP8_ADDR_W;
    localparam int OFS_W = $clog2(`PDP8_PAGE_WORDS);

    logic [0:W-1]          mem [`PDP8_MEM_WORDS];
    logic [0:W-1]          ir;
    logic [0:AW-1]         ea;
    logic [0:AW-1]         ea_fetch;
    logic [0:AW-1]         mem_addr;
    logic [0:W-1]          mdout_inc;
    logic [0:W-1]          mem_wdata;
    logic                  mem_we;
    pdp8_isa_pkg::opcode_t opcode;

    assign mem_addr = (state == pdp8_isa_pkg::ST_FETCH || state == pdp8_isa_pkg::ST_HALT)
                      ? pc : ea;
    assign mdout       = mem[mem_addr];
    assign mdout_inc   = mdout + 1'b1;
    assign instruction = (state == pdp8_isa_pkg::ST_FETCH) ? mdout : ir;
    assign opcode      = pdp8_isa_pkg::opcode_t'(instruction[0:2]);

    // Page zero or the page holding the instruction.
    assign ea_fetch = mdout[pdp8_isa_pkg::PAGE_BIT]
                      ? {pc[0:AW-OFS_W-1], mdout[W-OFS_W:W-1]}
                      : {{(AW-OFS_W){1'b0}}, mdout[W-OFS_W:W-1]};

    always_comb
    begin
        mem_we    = 1'b0;
        mem_wdata = sr;
        if (state == pdp8_isa_pkg::ST_HALT)
            mem_we = (panel_cmd == panel_pkg::PNL_DEP);
        else if (state == pdp8_isa_pkg::ST_EXEC)
        begin
            case (opcode)
                pdp8_isa_pkg::OP_ISZ:
                begin
                    mem_we    = 1'b1;
                    mem_wdata = mdout_inc;
                end
                pdp8_isa_pkg::OP_DCA:
                begin
                    mem_we    = 1'b1;
                    mem_wdata = ac;
                end
                pdp8_isa_pkg::OP_JMS:
                begin
                    mem_we    = 1'b1;
                    mem_wdata = pc;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (mem_we)
            mem[mem_addr] <= mem_wdata;
        if (state == pdp8_isa_pkg::ST_FETCH)
            ea <= ea_fetch;
        else if (state == pdp8_isa_pkg::ST_DEFER)
            ea <= mdout;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc <= '0;
            ir <= '0;
            mb <= '0;
        end
        else if (state == pdp8_isa_pkg::ST_HALT)
        begin
            case (panel_cmd)
                panel_pkg::PNL_LOAD: pc <= sr;
                panel_pkg::PNL_DEP:
                begin
                    mb <= sr;
                    pc <= pc + 1'b1;
                end
                panel_pkg::PNL_EXAM:
                begin
                    mb <= mdout;
                    pc <= pc + 1'b1;
                end
                default: ;
            endcase
        end
        else if (state == pdp8_isa_pkg::ST_FETCH)
        begin
            ir <= mdout;
            pc <= pc + 1'b1;
        end
        else if (state == pdp8_isa_pkg::ST_EXEC)
        begin
            case (opcode)
                pdp8_isa_pkg::OP_ISZ: if (mdout_inc == '0) pc <= pc + 1'b1;
                pdp8_isa_pkg::OP_JMS: pc <= ea + 1'b1;
                pdp8_isa_pkg::OP_JMP: pc <= ea;
                pdp8_isa_pkg::OP_OPR: if (skip) pc <= pc + 1'b1;
                default: ;
            endcase
        end
    end

    // Execute stores follow a fetch or defer cycle.
    a_write_state: assert property (@(posedge clk) disable iff (!rst_n)
        mem_we && state == pdp8_isa_pkg::ST_EXEC |->
            $past(state) == pdp8_isa_pkg::ST_FETCH ||
            $past(state) == pdp8_isa_pkg::ST_DEFER);

endmodule

`default_nettype wire

// File: logic/oper2.sv
// Group 2 skip and halt decode

`timescale 1ns/1ps
`default_nettype none

`include "pdp8_cfg.svh"

module oper2 (
    input  pdp8_isa_pkg::major_state_t state,
    input  logic [0:`PDP8_WORD_W-1]    instruction,
    input  logic [0:`PDP8_WORD_W-1]    ac,
    input  logic                       link,
    output logic                       skip,
    output logic                       halt_req
);
    logic grp2_exec;
    logic cond;

    assign grp2_exec = (state == pdp8_isa_pkg::ST_EXEC) &&
                       (instruction[0:2] == pdp8_isa_pkg::OP_OPR) &&
                       instruction[pdp8_isa_pkg::GRP_BIT];

    // Sees ac and link ahead of this instruction's CLA.
    assign cond = (instruction[pdp8_isa_pkg::SMA_BIT] && ac[0]) ||
                  (instruction[pdp8_isa_pkg::SZA_BIT] && ac == '0) ||
                  (instruction[pdp8_isa_pkg::SNL_BIT] && link);

    // Reverse sense with nothing selected is an unconditional skip.
    assign skip     = grp2_exec && (cond ^ instruction[pdp8_isa_pkg::REV_BIT]);
    assign halt_req = grp2_exec && instruction[pdp8_isa_pkg::HLT_BIT];

endmodule

`default_nettype wire

// File: logic/panel_pkg.sv
// Front panel command encoding

`default_nettype none

package panel_pkg;

    typedef enum logic [2:0] {
        PNL_NONE = 3'd0,
        PNL_LOAD = 3'd1,
        PNL_DEP  = 3'd2,
        PNL_EXAM = 3'd3,
        PNL_CONT = 3'd4
    } panel_cmd_t;

endpackage

`default_nettype wire

// File: logic/pdp8_cfg.svh
// PDP-8 core sizing

`ifndef PDP8_CFG_SVH
`define PDP8_CFG_SVH

// Twelve-bit words and addresses.
`define PDP8_WORD_W 12
`define PDP8_ADDR_W 12

// One 4K field of core.
`define PDP8_MEM_WORDS 4096

// Words per memory page.
`define PDP8_PAGE_WORDS 128

`endif

// File: logic/pdp8_core.sv
// PDP-8 processor core

`timescale 1ns/1ps
`default_nettype none

`include "pdp8_cfg.svh"

module pdp8_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [0:`PDP8_WORD_W-1] sr,
    input  logic                    load_sw,
    input  logic                    dep_sw,
    input  logic                    exam_sw,
    input  logic                    cont_sw,
    output logic [0:`PDP8_WORD_W-1] ac,
    output logic [0:`PDP8_WORD_W-1] mb,
    output logic [0:`PDP8_ADDR_W-1] pc,
    output logic                    link,
    output logic                    run
);
    panel_pkg::panel_cmd_t      panel_cmd;
    pdp8_isa_pkg::major_state_t state;
    logic [0:`PDP8_WORD_W-1]    instruction;
    logic [0:`PDP8_WORD_W-1]    mdout;
    logic                       skip;
    logic                       halt_req;

    front_panel u_front_panel (
        .clk(clk), .rst_n(rst_n), .run(run),
        .load_sw(load_sw), .dep_sw(dep_sw), .exam_sw(exam_sw), .cont_sw(cont_sw),
        .panel_cmd(panel_cmd)
    );

    state_machine u_state_machine (
        .clk(clk), .rst_n(rst_n), .panel_cmd(panel_cmd), .instruction(instruction),
        .halt_req(halt_req), .state(state), .run(run)
    );

    ma u_ma (
        .clk(clk), .rst_n(rst_n), .state(state), .panel_cmd(panel_cmd),
        .sr(sr), .ac(ac), .skip(skip),
        .instruction(instruction), .mdout(mdout), .pc(pc), .mb(mb)
    );

    ac u_ac (
        .clk(clk), .rst_n(rst_n), .state(state), .instruction(instruction),
        .mdout(mdout), .sr(sr), .ac(ac), .link(link)
    );

    oper2 u_oper2 (
        .state(state), .instruction(instruction), .ac(ac), .link(link),
        .skip(skip), .halt_req(halt_req)
    );

endmodule

`default_nettype wire

// File: logic/pdp8_isa_pkg.sv
// PDP-8 instruction set definitions

`default_nettype none

package pdp8_isa_pkg;

    typedef enum logic [1:0] {
        ST_HALT  = 2'd0,
        ST_FETCH = 2'd1,
        ST_DEFER = 2'd2,
        ST_EXEC  = 2'd3
    } major_state_t;

    // Instruction bits 0 to 2.
    typedef enum logic [2:0] {
        OP_AND = 3'd0,
        OP_TAD = 3'd1,
        OP_ISZ = 3'd2,
        OP_DCA = 3'd3,
        OP_JMS = 3'd4,
        OP_JMP = 3'd5,
        OP_IOT = 3'd6,
        OP_OPR = 3'd7
    } opcode_t;

    // Memory reference fields.
    localparam int unsigned IND_BIT  = 3;
    localparam int unsigned PAGE_BIT = 4;

    // Operate group select, set for group 2.
    localparam int unsigned GRP_BIT  = 3;

    // Group 1 microcode.
    localparam int unsigned CLA_BIT  = 4;
    localparam int unsigned CLL_BIT  = 5;
    localparam int unsigned CMA_BIT  = 6;
    localparam int unsigned CML_BIT  = 7;
    localparam int unsigned RAR_BIT  = 8;
    localparam int unsigned RAL_BIT  = 9;
    localparam int unsigned TWO_BIT  = 10;
    localparam int unsigned IAC_BIT  = 11;

    // Group 2 microcode, CLA shared with group 1.
    localparam int unsigned SMA_BIT  = 5;
    localparam int unsigned SZA_BIT  = 6;
    localparam int unsigned SNL_BIT  = 7;
    localparam int unsigned REV_BIT  = 8;
    localparam int unsigned OSR_BIT  = 9;
    localparam int unsigned HLT_BIT  = 10;

endpackage

`default_nettype wire

// File: logic/state_machine.sv
// Major state sequencer

`timescale 1ns/1ps
`default_nettype none

`include "pdp8_cfg.svh"

module state_machine (
    input  logic                        clk,
    input  logic                        rst_n,
    input  panel_pkg::panel_cmd_t       panel_cmd,
    input  logic [0:`PDP8_WORD_W-1]     instruction,
    input  logic                        halt_req,
    output pdp8_isa_pkg::major_state_t  state,
    output logic                        run
);
    pdp8_isa_pkg::opcode_t opcode;
    logic                  mem_ref;
    logic                  indirect;

    assign opcode   = pdp8_isa_pkg::opcode_t'(instruction[0:2]);
    assign mem_ref  = (opcode != pdp8_isa_pkg::OP_IOT) && (opcode != pdp8_isa_pkg::OP_OPR);
    assign indirect = mem_ref && instruction[pdp8_isa_pkg::IND_BIT];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= pdp8_isa_pkg::ST_HALT;
            run   <= 1'b0;
        end
        else
        begin
            case (state)
                pdp8_isa_pkg::ST_HALT:
                begin
                    if (panel_cmd == panel_pkg::PNL_CONT)
                    begin
                        state <= pdp8_isa_pkg::ST_FETCH;
                        run   <= 1'b1;
                    end
                end
                pdp8_isa_pkg::ST_FETCH:
                begin
                    // Instruction word is still on the memory output here.
                    if (indirect)
                        state <= pdp8_isa_pkg::ST_DEFER;
                    else
                        state <= pdp8_isa_pkg::ST_EXEC;
                end
                pdp8_isa_pkg::ST_DEFER:
                    state <= pdp8_isa_pkg::ST_EXEC;
                default:
                begin
                    if (halt_req)
                    begin
                        state <= pdp8_isa_pkg::ST_HALT;
                        run   <= 1'b0;
                    end
                    else
                        state <= pdp8_isa_pkg::ST_FETCH;
                end
            endcase
        end
    end

    // Panel commands only arrive while the machine sits in HALT.
    a_cmd_in_halt: assert property (@(posedge clk) disable iff (!rst_n)
        panel_cmd != panel_pkg::PNL_NONE |-> state == pdp8_isa_pkg::ST_HALT);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the PDP-8 core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_pdp8 -o sim_tb_pdp8
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb_pdp8 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// File: tb.f
+incdir+logic
logic/pdp8_isa_pkg.sv
logic/panel_pkg.sv
logic/front_panel.sv
logic/state_machine.sv
logic/ma.sv
logic/ac.sv
logic/oper2.sv
logic/pdp8_core.sv
tb/tb_pdp8.sv

// File: tb/tb_pdp8.sv
// PDP-8 core testbench

`timescale 1ns/1ps
`default_nettype none

`include "pdp8_cfg.svh"

module tb_pdp8;
    localparam int W         = `PDP8_WORD_W;
    localparam int SW_LOAD   = 0;
    localparam int SW_DEP    = 1;
    localparam int SW_EXAM   = 2;
    // Bound on cycles per test section.
    localparam int N_PROGS   = 24;
    localparam int WORDS     = 110;
    localparam int MAX_STEPS = 1100;
    localparam int LIMIT     = N_PROGS * (WORDS * 6 + MAX_STEPS * 3) + 2000;
    localparam int MODEL_STEPS = 2000;

    logic         clk = 1'b0;
    logic         rst_n;
    logic [W-1:0] sr;
    logic         load_sw;
    logic         dep_sw;
    logic         exam_sw;
    logic         cont_sw;
    wire  [W-1:0] ac;
    wire  [W-1:0] mb;
    wire  [W-1:0] pc;
    wire          link;
    wire          run;

    // Reference machine state and a mirror of core memory.
    logic [W-1:0] mem_img [0:`PDP8_MEM_WORDS-1];
    logic [W-1:0] m_ac;
    logic         m_link;
    logic [W-1:0] m_pc;
    logic [W-1:0] cur_addr;
    logic [31:0]  rng;
    int           cycles = 0;

    pdp8_core UUT (
        .clk(clk), .rst_n(rst_n), .sr(sr),
        .load_sw(load_sw), .dep_sw(dep_sw), .exam_sw(exam_sw), .cont_sw(cont_sw),
        .ac(ac), .mb(mb), .pc(pc), .link(link), .run(run)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT)
        begin
            $display("Timeout: the run did not finish within the cycle limit");
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [W-1:0] rand_word();
        logic [31:0] r;
        r = next_rand();
        return r[W-1:0];
    endfunction

    // Instruction set model, runs on mem_img until HLT.
    function automatic int run_model(input logic [W-1:0] start, input logic [W-1:0] swr);
        logic [W-1:0] ir;
        logic [W-1:0] addr;
        logic [W-1:0] ea;
        logic [W-1:0] val;
        logic [W:0]   la;
        logic         cond;
        m_pc = start;
        for (int steps = 1; steps <= MODEL_STEPS; steps++)
        begin
            addr = m_pc;
            ir   = mem_img[addr];
            m_pc = m_pc + 12'd1;
            ea   = ir[7] ? {addr[11:7], ir[6:0]} : {5'd0, ir[6:0]};
            if (ir[8] && ir[11:9] < 3'd6)
                ea = mem_img[ea];
            case (ir[11:9])
                3'd0: m_ac = m_ac & mem_img[ea];
                3'd1:
                begin
                    la     = {1'b0, m_ac} + {1'b0, mem_img[ea]};
                    m_ac   = la[11:0];
                    m_link = m_link ^ la[12];
                end
                3'd2:
                begin
                    val         = mem_img[ea] + 12'd1;
                    mem_img[ea] = val;
                    if (val == 12'd0)
                        m_pc = m_pc + 12'd1;
                end
                3'd3:
                begin
                    mem_img[ea] = m_ac;
                    m_ac        = 12'd0;
                end
                3'd4:
                begin
                    mem_img[ea] = m_pc;
                    m_pc        = ea + 12'd1;
                end
                3'd5: m_pc = ea;
                3'd7:
                begin
                    if (!ir[8])
                    begin
                        la = {m_link, m_ac};
                        if (ir[7]) la[11:0] = 12'd0;
                        if (ir[6]) la[12] = 1'b0;
                        if (ir[5]) la[11:0] = ~la[11:0];
                        if (ir[4]) la[12] = ~la[12];
                        if (ir[0]) la = la + 13'd1;
                        case (ir[3:1])
                            3'b100: la = {la[0], la[12:1]};
                            3'b101: la = {la[1:0], la[12:2]};
                            3'b010: la = {la[11:0], la[12]};
                            3'b011: la = {la[10:0], la[12:11]};
                            3'b001: la[11:0] = {la[5:0], la[11:6]};
                            default: ;
                        endcase
                        m_link = la[12];
                        m_ac   = la[11:0];
                    end
                    else
                    begin
                        cond = (ir[6] && m_ac[11]) || (ir[5] && m_ac == 12'd0) ||
                               (ir[4] && m_link);
                        if (cond ^ ir[3])
                            m_pc = m_pc + 12'd1;
                        if (ir[7]) m_ac = 12'd0;
                        if (ir[2]) m_ac = m_ac | swr;
                        if (ir[1])
                            return steps;
                    end
                end
                default: ;
            endcase
        end
        return -1;
    endfunction

    task automatic check_word(input logic [W-1:0] got, input logic [W-1:0] exp,
                              input string what);
        assert (got === exp)
        else
        begin
            $display("Fail at %0t ns: %s is %04o, expected %04o", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic press(input int which);
        @(negedge clk);
        case (which)
            SW_LOAD: load_sw = 1'b1;
            SW_DEP:  dep_sw  = 1'b1;
            SW_EXAM: exam_sw = 1'b1;
            default: cont_sw = 1'b1;
        endcase
        @(negedge clk);
        load_sw = 1'b0;
        dep_sw  = 1'b0;
        exam_sw = 1'b0;
        cont_sw = 1'b0;
        repeat (5) @(negedge clk);
    endtask

    task automatic load_addr(input logic [W-1:0] a);
        sr = a;
        press(SW_LOAD);
        check_word(pc, a, "pc after LOAD");
        cur_addr = a;
    endtask

    task automatic deposit_at(input logic [W-1:0] a, input logic [W-1:0] w);
        if (a !== cur_addr)
            load_addr(a);
        sr = w;
        press(SW_DEP);
        mem_img[a] = w;
        cur_addr   = a + 12'd1;
        check_word(pc, cur_addr, "pc after DEP");
    endtask

    task automatic examine_at(input logic [W-1:0] a);
        if (a !== cur_addr)
            load_addr(a);
        press(SW_EXAM);
        check_word(mb, mem_img[a], "mb after EXAM");
        cur_addr = a + 12'd1;
        check_word(pc, cur_addr, "pc after EXAM");
    endtask

    task automatic start_run(input logic [W-1:0] start, input logic [W-1:0] swr);
        int n;
        if (start !== cur_addr)
            load_addr(start);
        if (run_model(start, swr) < 0)
            abort_run("Reference model never reached a HLT");
        sr = swr;
        @(negedge clk);
        cont_sw = 1'b1;
        @(negedge clk);
        cont_sw = 1'b0;
        n = 0;
        while (!run && n < 8)
        begin
            @(negedge clk);
            n++;
        end
        if (!run)
            abort_run("Machine did not start after CONT");
    endtask

    task automatic finish_run();
        while (run)
            @(negedge clk);
        repeat (2) @(negedge clk);
        check_word(ac, m_ac, "ac after HLT");
        check_word({11'd0, link}, {11'd0, m_link}, "link after HLT");
        check_word(pc, m_pc, "pc after HLT");
        cur_addr = m_pc;
    endtask

    task automatic random_program();
        logic [31:0] r;
        logic [4:0]  page;
        logic [6:0]  off;
        logic [11:0] w;
        r    = next_rand();
        page = 5'd4 + {1'b0, r[3:0]};
        for (off = 7'o20; off < 7'o30; off++)
        begin
            r = next_rand();
            w = r[4] ? {5'd0, 3'b010, r[3:0]} : {page, 3'b100, r[3:0]};
            deposit_at({5'd0, off}, w);
        end
        for (off = 7'o40; off < 7'o60; off++)
            deposit_at({5'd0, off}, rand_word());
        for (off = 7'o100; off < 7'o120; off++)
            deposit_at({page, off}, rand_word());
        for (off = 7'd0; off < 7'd20; off++)
        begin
            r = next_rand();
            if (r[2:0] < 3'd4)
                w = r[3] ? {1'b0, r[1:0], 2'b10, 4'b0010, r[6:4]}
                  : (r[4] ? {1'b0, r[1:0], 2'b00, 3'b010, r[8:5]}
                          : {1'b0, r[1:0], 2'b01, 3'b100, r[8:5]});
            else if (r[2:0] < 3'd6)
                w = {3'b111, 1'b0, r[15:8]};
            else
                w = {3'b111, 1'b1, r[15:10], 2'b00};
            deposit_at({page, off}, w);
        end
        deposit_at({page, 7'd20}, 12'o7402);
        deposit_at({page, 7'd21}, 12'o7402);
        r = next_rand();
        start_run({page, 7'd0}, r[11:0]);
        finish_run();
        for (off = 7'o40; off < 7'o60; off++)
            examine_at({5'd0, off});
        for (off = 7'o100; off < 7'o120; off++)
            examine_at({page, off});
    endtask

    initial
    begin
        logic [31:0] r;
        logic [11:0] base;
        logic [3:0]  k;
        rng      = 32'hc9fd;
        rst_n    = 1'b0;
        sr       = 12'd0;
        load_sw  = 1'b0;
        dep_sw   = 1'b0;
        exam_sw  = 1'b0;
        cont_sw  = 1'b0;
        m_ac     = 12'd0;
        m_link   = 1'b0;
        cur_addr = 12'd0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_word({11'd0, run}, 12'd0, "run after reset");
        check_word(ac, 12'd0, "ac after reset");
        check_word({11'd0, link}, 12'd0, "link after reset");
        check_word(pc, 12'd0, "pc after reset");
        check_word(mb, 12'd0, "mb after reset");

        // Deposit and examine round trip.
        r    = next_rand();
        base = {2'b01, r[9:0]};
        for (k = 4'd0; k < 4'd8; k++)
            deposit_at(base + {8'd0, k}, rand_word());
        load_addr(base);
        for (k = 4'd0; k < 4'd8; k++)
            examine_at(base + {8'd0, k});

        repeat (4) random_program();

        // Subroutine called three times under ISZ control.
        deposit_at(12'o0200, 12'o7300);
        deposit_at(12'o0201, 12'o4210);
        deposit_at(12'o0202, 12'o2220);
        deposit_at(12'o0203, 12'o5201);
        deposit_at(12'o0204, 12'o7402);
        deposit_at(12'o0210, 12'o0000);
        deposit_at(12'o0211, 12'o1221);
        deposit_at(12'o0212, 12'o5610);
        deposit_at(12'o0220, 12'o7775);
        deposit_at(12'o0221, 12'o0005);
        start_run(12'o0200, 12'd0);
        finish_run();
        examine_at(12'o0210);
        examine_at(12'o0220);

        // Every skip condition in both senses.
        for (int c = 0; c < 8; c++)
        begin
            for (int rev = 0; rev < 2; rev++)
            begin
                r = next_rand();
                deposit_at(12'o0300, 12'o7300);
                deposit_at(12'o0301, 12'o1310);
                deposit_at(12'o0302, r[2] ? 12'o7020 : 12'o7000);
                deposit_at(12'o0303, {5'b11110, c[2:0], rev[0], 3'b010});
                deposit_at(12'o0304, 12'o7402);
                case (r[1:0])
                    2'd0: deposit_at(12'o0310, 12'o0000);
                    2'd1: deposit_at(12'o0310, 12'o4000);
                    2'd2: deposit_at(12'o0310, 12'o0001);
                    default: deposit_at(12'o0310, r[15:4]);
                endcase
                start_run(12'o0300, 12'd0);
                finish_run();
            end
        end

        // Long loop with panel presses while running, then CONT resume.
        deposit_at(12'o1000, 12'o2220);
        deposit_at(12'o1001, 12'o5200);
        deposit_at(12'o1002, 12'o7402);
        deposit_at(12'o1003, 12'o7001);
        deposit_at(12'o1004, 12'o7402);
        deposit_at(12'o1020, 12'o7000);
        start_run(12'o1000, 12'd0);
        sr = 12'o0000;
        press(SW_LOAD);
        sr = 12'o7777;
        press(SW_DEP);
        press(SW_EXAM);
        if (!run)
            abort_run("Loop program halted before the panel presses ended");
        finish_run();
        start_run(cur_addr, 12'd0);
        finish_run();
        for (k = 4'd0; k < 4'd5; k++)
            examine_at(12'o1000 + {8'd0, k});
        examine_at(12'o1020);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
